// ==== rtl/booth_pp_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module booth_pp_gen
(
  input  wire                clk,
  input  wire                rst_n,
  input  wire                issue_valid,   // one op per cycle max
  input  wire mul_pkg::operand_t x,         // multiplier, gets recoded
  input  wire mul_pkg::operand_t y,         // multiplicand
  output logic               pp_valid,
  output mul_pkg::pp_table_t pp_table
);

  // ====================
  // booth digits
  // ====================
  logic [34:0] xa;    // {00, x, 0}, one triplet per digit
  logic [16:0] neg;   // digit is negative
  logic [16:0] one;   // |digit| == 1
  logic [16:0] two;   // |digit| == 2

  always_comb
  begin
    xa = {2'b00, x, 1'b0};
    for (int k = 0; k < 17; k++)
    begin
      // triplet is x[2k+1] x[2k] x[2k-1]
      case (xa[2*k+2 -: 3])
        3'b000,
        3'b111:  {neg[k], two[k], one[k]} = 3'b0_0_0;  // 0
        3'b001,
        3'b010:  {neg[k], two[k], one[k]} = 3'b0_0_1;  // +1
        3'b011:  {neg[k], two[k], one[k]} = 3'b0_1_0;  // +2
        3'b100:  {neg[k], two[k], one[k]} = 3'b1_1_0;  // -2
        3'b101,
        3'b110:  {neg[k], two[k], one[k]} = 3'b1_0_1;  // -1
        default: {neg[k], two[k], one[k]} = 3'b0_0_0;
      endcase
    end
  end

  // top two xa bits are zero so neg[16] never sets
  // and the last row needs no +1 of its own

  // ====================
  // row build
  // ====================
  logic [32:0]        mag;    // 0, y or 2y
  logic [32:0]        pp;     // mag, ones' complement if neg
  logic [67:0]        wide;   // row before truncation to 64
  mul_pkg::pp_table_t pp_d;

  always_comb
  begin
    pp_d = '0;
    for (int k = 0; k < 17; k++)
    begin
      case ({two[k], one[k]})
        2'b10:   mag = {y, 1'b0};
        2'b01:   mag = {1'b0, y};
        default: mag = '0;
      endcase
      pp = neg[k] ? ~mag : mag;

      wide = '0;
      wide[2*k +: 33] = pp;          // 33-bit multiple at weight 4^k
      if (k == 0)
      begin
        // first row carries its full sign extension
        wide[33 +: 3] = {~neg[0], neg[0], neg[0]};
      end
      else
      begin
        wide[2*k+33] = ~neg[k];      // inverted sign
        wide[2*k+34] = 1'b1;         // constant one of the ext scheme
        wide[2*k-2]  = neg[k-1];     // +1 completing the row above
      end
      pp_d[k] = wide[63:0];          // bits past 63 drop out mod 2^64
    end
  end

  // ====================
  // stage 1 register
  // ====================
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      pp_valid <= 1'b0;
    else
      pp_valid <= issue_valid;
  end

  // table only moves with a live op
  always_ff @(posedge clk)
  begin
    if (issue_valid)
      pp_table <= pp_d;
  end

endmodule : booth_pp_gen

`default_nettype wire

// ==== rtl/csa_tree.sv ====
`timescale 1ns/1ps
`default_nettype none

module csa_tree
(
  input  wire                clk,
  input  wire                rst_n,
  input  wire                pp_valid,
  input  wire mul_pkg::pp_table_t pp_table,   // 17 aligned rows
  output logic               prod_valid,
  output mul_pkg::product_t  prod
);

  // ====================
  // compressors
  // ====================

  // 3:2, one full adder per column
  function automatic mul_pkg::csa_pair_t csa32
  (
    input mul_pkg::pp_row_t a,
    input mul_pkg::pp_row_t b,
    input mul_pkg::pp_row_t c
  );
    mul_pkg::csa_pair_t r;
    r.sum   = a ^ b ^ c;
    r.carry = ((a & b) | (a & c) | (b & c)) << 1;   // top carry lost, mod 2^64
    return r;
  endfunction

  // 4:2 built from two chained 3:2
  function automatic mul_pkg::csa_pair_t csa42
  (
    input mul_pkg::pp_row_t a,
    input mul_pkg::pp_row_t b,
    input mul_pkg::pp_row_t c,
    input mul_pkg::pp_row_t d
  );
    mul_pkg::csa_pair_t lo;
    mul_pkg::csa_pair_t hi;
    lo = csa32(b, c, d);
    hi = csa32(a, lo.sum, lo.carry);   // carry-in is the shifted lo carry
    return hi;
  endfunction

  // ====================
  // levels 1 and 2
  // ====================
  mul_pkg::csa_pair_t lvl1 [4];   // 16 rows -> 8
  mul_pkg::csa_pair_t lvl2 [2];   // 8 -> 4

  always_comb
  begin
    for (int i = 0; i < 4; i++)
    begin
      lvl1[i] = csa42(pp_table[4*i], pp_table[4*i+1],
                      pp_table[4*i+2], pp_table[4*i+3]);
    end
    for (int i = 0; i < 2; i++)
    begin
      lvl2[i] = csa42(lvl1[2*i].sum, lvl1[2*i].carry,
                      lvl1[2*i+1].sum, lvl1[2*i+1].carry);
    end
  end

  // stage 2 register, four vectors plus the odd row 16
  mul_pkg::pp_row_t s2_row [5];
  logic             s2_valid;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      s2_valid <= 1'b0;
    else
      s2_valid <= pp_valid;
  end

  always_ff @(posedge clk)
  begin
    if (pp_valid)
    begin
      s2_row[0] <= lvl2[0].sum;
      s2_row[1] <= lvl2[0].carry;
      s2_row[2] <= lvl2[1].sum;
      s2_row[3] <= lvl2[1].carry;
      s2_row[4] <= pp_table[16];   // skips the first two levels
    end
  end

  // ====================
  // levels 3, 4 and cpa
  // ====================
  mul_pkg::csa_pair_t lvl3;
  mul_pkg::csa_pair_t lvl4;
  mul_pkg::product_t  sum_d;

  always_comb
  begin
    lvl3  = csa42(s2_row[0], s2_row[1], s2_row[2], s2_row[3]);
    lvl4  = csa32(lvl3.sum, lvl3.carry, s2_row[4]);   // fold in row 16
    sum_d = lvl4.sum + lvl4.carry;                    // carry-propagate add
  end

  // stage 3 register
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      prod_valid <= 1'b0;
    else
      prod_valid <= s2_valid;
  end

  always_ff @(posedge clk)
  begin
    if (s2_valid)
      prod <= sum_d;
  end

endmodule : csa_tree

`default_nettype wire

// ==== rtl/mul_cfg.svh ====
`ifndef MUL_CFG_SVH
`define MUL_CFG_SVH

// ====================
// register map
// ====================
`define MUL_AXI_ADDR_W  5        // byte address bits
`define MUL_REG_X       5'h00    // operand x
`define MUL_REG_Y       5'h04    // operand y
`define MUL_REG_CTRL    5'h08    // wr bit0 start, rd {done, busy}
`define MUL_REG_PROD_LO 5'h0C    // product bits 31..0
`define MUL_REG_PROD_HI 5'h10    // product bits 63..32
`define MUL_REG_COUNT   5'h14    // completed ops

// ====================
// datapath
// ====================
`define MUL_PIPE_DEPTH  3        // issue to result, cycles

`endif

// ==== rtl/mul_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mul_cfg.svh"

module mul_ctrl
(
  input  wire                          clk,
  input  wire                          rst_n,
  // write address + data
  input  wire [`MUL_AXI_ADDR_W-1:0]    awaddr,
  input  wire                          awvalid,
  output logic                         awready,
  input  wire [31:0]                   wdata,
  input  wire                          wvalid,
  output logic                         wready,
  // write response
  output logic                         bvalid,
  output mul_pkg::axi_resp_t           bresp,
  input  wire                          bready,
  // read address
  input  wire [`MUL_AXI_ADDR_W-1:0]    araddr,
  input  wire                          arvalid,
  output logic                         arready,
  // read data
  output logic                         rvalid,
  output logic [31:0]                  rdata,
  output mul_pkg::axi_resp_t           rresp,
  input  wire                          rready,
  // to booth stage
  output logic                         issue_valid,
  output mul_pkg::operand_t            x,
  output mul_pkg::operand_t            y,
  // back from adder stage
  input  wire                          prod_valid,
  input  wire mul_pkg::product_t       prod
);

  logic                       aw_w_rdy;   // shared awready / wready
  logic                       wr_en;      // aw + w handshake this cycle
  logic                       wr_hit;     // write offset is mapped
  logic                       ar_rdy;
  logic                       rd_en;
  logic [31:0]                rd_word;
  mul_pkg::axi_resp_t         rd_resp;
  logic [`MUL_PIPE_DEPTH-1:0] inflight;   // one bit per pipe stage
  logic                       busy;
  logic                       done;       // sticky, cleared by ctrl read
  mul_pkg::product_t          prod_q;     // last result
  logic [31:0]                count;

  // ====================
  // write channel
  // ====================
  assign awready = aw_w_rdy;
  assign wready  = aw_w_rdy;
  assign wr_en   = aw_w_rdy & awvalid & wvalid;

  always_comb
  begin
    case (awaddr)
      `MUL_REG_X,
      `MUL_REG_Y,
      `MUL_REG_CTRL,
      `MUL_REG_PROD_LO,
      `MUL_REG_PROD_HI,
      `MUL_REG_COUNT: wr_hit = 1'b1;   // result regs ignore writes
      default:        wr_hit = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      aw_w_rdy    <= 1'b0;
      bvalid      <= 1'b0;
      bresp       <= mul_pkg::OKAY;
      issue_valid <= 1'b0;
      x           <= '0;
      y           <= '0;
    end
    else
    begin
      // single pulse, held off while a response waits
      aw_w_rdy    <= ~aw_w_rdy & awvalid & wvalid & ~bvalid;
      issue_valid <= wr_en & (awaddr == `MUL_REG_CTRL) & wdata[0];
      if (wr_en)
      begin
        bvalid <= 1'b1;
        bresp  <= wr_hit ? mul_pkg::OKAY : mul_pkg::SLVERR;
        if (awaddr == `MUL_REG_X)
          x <= wdata;
        if (awaddr == `MUL_REG_Y)
          y <= wdata;
      end
      else if (bvalid && bready)
        bvalid <= 1'b0;
    end
  end

  // ====================
  // read channel
  // ====================
  assign arready = ar_rdy;
  assign rd_en   = ar_rdy & arvalid;

  always_comb
  begin
    rd_word = '0;
    rd_resp = mul_pkg::OKAY;
    case (araddr)
      `MUL_REG_X:       rd_word = x;
      `MUL_REG_Y:       rd_word = y;
      `MUL_REG_CTRL:    rd_word = {30'd0, done, busy};
      `MUL_REG_PROD_LO: rd_word = prod_q[31:0];
      `MUL_REG_PROD_HI: rd_word = prod_q[63:32];
      `MUL_REG_COUNT:   rd_word = count;
      default:          rd_resp = mul_pkg::SLVERR;   // data stays zero
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ar_rdy <= 1'b0;
      rvalid <= 1'b0;
      rdata  <= '0;
      rresp  <= mul_pkg::OKAY;
    end
    else
    begin
      ar_rdy <= ~ar_rdy & arvalid & ~rvalid;
      if (rd_en)
      begin
        rvalid <= 1'b1;
        rdata  <= rd_word;   // held until rready
        rresp  <= rd_resp;
      end
      else if (rvalid && rready)
        rvalid <= 1'b0;
    end
  end

  // ====================
  // results and status
  // ====================

  // an op counts as busy from its issue cycle until the
  // cycle its product lands
  assign busy = issue_valid | (|inflight);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      inflight <= '0;
      done     <= 1'b0;
      prod_q   <= '0;
      count    <= '0;
    end
    else
    begin
      inflight <= {inflight[`MUL_PIPE_DEPTH-2:0], issue_valid};
      if (rd_en && araddr == `MUL_REG_CTRL)
        done <= 1'b0;                   // read to clear
      if (prod_valid)
      begin
        prod_q <= prod;                 // results come back in issue order
        count  <= count + 32'd1;
        done   <= 1'b1;                 // wins over a same-cycle clear
      end
    end
  end

endmodule : mul_ctrl

`default_nettype wire

// ==== rtl/mul_pkg.sv ====
`default_nettype none

package mul_pkg;

  // ====================
  // operands and result
  // ====================
  typedef logic [31:0] operand_t;   // unsigned x or y
  typedef logic [63:0] product_t;   // unsigned x*y

  // one row of the aligned booth table
  typedef logic [63:0] pp_row_t;

  // 17 rows, row k sits at weight 4^k
  typedef pp_row_t [16:0] pp_table_t;

  // redundant form out of a compressor
  typedef struct packed {
    pp_row_t sum;     // xor of inputs
    pp_row_t carry;   // already shifted up one place
  } csa_pair_t;

  // ====================
  // bus codes
  // ====================
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_t;

endpackage : mul_pkg

`default_nettype wire

// ==== rtl/mul_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mul_cfg.svh"

module mul_top
(
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire [`MUL_AXI_ADDR_W-1:0]    awaddr,
  input  wire                          awvalid,
  output logic                         awready,
  input  wire [31:0]                   wdata,
  input  wire                          wvalid,
  output logic                         wready,
  output logic                         bvalid,
  output mul_pkg::axi_resp_t           bresp,
  input  wire                          bready,
  input  wire [`MUL_AXI_ADDR_W-1:0]    araddr,
  input  wire                          arvalid,
  output logic                         arready,
  output logic                         rvalid,
  output logic [31:0]                  rdata,
  output mul_pkg::axi_resp_t           rresp,
  input  wire                          rready
);

  // ====================
  // pipeline nets
  // ====================
  logic               issue_valid;
  mul_pkg::operand_t  x;
  mul_pkg::operand_t  y;
  logic               pp_valid;     // stage 1 out
  mul_pkg::pp_table_t pp_table;
  logic               prod_valid;   // stage 3 out
  mul_pkg::product_t  prod;

  // bus slave and register file
  mul_ctrl i_ctrl
  (
    .clk         (clk),
    .rst_n       (rst_n),
    .awaddr      (awaddr),
    .awvalid     (awvalid),
    .awready     (awready),
    .wdata       (wdata),
    .wvalid      (wvalid),
    .wready      (wready),
    .bvalid      (bvalid),
    .bresp       (bresp),
    .bready      (bready),
    .araddr      (araddr),
    .arvalid     (arvalid),
    .arready     (arready),
    .rvalid      (rvalid),
    .rdata       (rdata),
    .rresp       (rresp),
    .rready      (rready),
    .issue_valid (issue_valid),
    .x           (x),
    .y           (y),
    .prod_valid  (prod_valid),
    .prod        (prod)
  );

  // recode + partial products
  booth_pp_gen i_booth
  (
    .clk         (clk),
    .rst_n       (rst_n),
    .issue_valid (issue_valid),
    .x           (x),
    .y           (y),
    .pp_valid    (pp_valid),
    .pp_table    (pp_table)
  );

  // reduction and final add
  csa_tree i_tree
  (
    .clk         (clk),
    .rst_n       (rst_n),
    .pp_valid    (pp_valid),
    .pp_table    (pp_table),
    .prod_valid  (prod_valid),
    .prod        (prod)
  );

endmodule : mul_top

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the multiply unit testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  -f verilog.f --top-module tb_mul_top -Mdir obj_dir

output="$(./obj_dir/Vtb_mul_top)"
echo "$output"

if grep -qx "TB PASSED" <<< "$output"; then
  exit 0
fi
exit 1

// ==== testbench/tb_mul_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mul_cfg.svh"

module tb_mul_top;

  localparam int num_tests       = 212;   // reset, directed, random, bus cases
  localparam int cycles_per_test = 200;

  logic                       clk;
  logic                       rst_n;
  logic [`MUL_AXI_ADDR_W-1:0] awaddr;
  logic                       awvalid;
  logic                       awready;
  logic [31:0]                wdata;
  logic                       wvalid;
  logic                       wready;
  logic                       bvalid;
  mul_pkg::axi_resp_t         bresp;
  logic                       bready;
  logic [`MUL_AXI_ADDR_W-1:0] araddr;
  logic                       arvalid;
  logic                       arready;
  logic                       rvalid;
  logic [31:0]                rdata;
  mul_pkg::axi_resp_t         rresp;
  logic                       rready;

  int                errors;
  int                checks;
  logic [15:0]       lfsr;        // random source state
  logic [31:0]       exp_count;   // starts issued so far
  mul_pkg::product_t exp_q [$];   // reference products
  mul_pkg::product_t got_q [$];   // products read back

  mul_top i_dut
  (
    .clk     (clk),
    .rst_n   (rst_n),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wvalid  (wvalid),
    .wready  (wready),
    .bvalid  (bvalid),
    .bresp   (bresp),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rvalid  (rvalid),
    .rdata   (rdata),
    .rresp   (rresp),
    .rready  (rready)
  );

  // ====================
  // clock and watchdog
  // ====================
  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;   // 8 ns period
  end

  initial
  begin
    repeat (num_tests * cycles_per_test) @(posedge clk);
    $display("timeout: tests did not finish within %0d cycles",
             num_tests * cycles_per_test);
    $display("TB FAILED");
    $finish;
  end

  // ====================
  // reference and checks
  // ====================

  // plain shift and add over the bits of a
  function automatic mul_pkg::product_t ref_mul
  (
    input mul_pkg::operand_t a,
    input mul_pkg::operand_t b
  );
    mul_pkg::product_t acc;
    acc = '0;
    for (int i = 0; i < 32; i++)
    begin
      if (a[i])
        acc = acc + ({32'd0, b} << i);
    end
    return acc;
  endfunction

  // taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_operand(output mul_pkg::operand_t w);
    for (int i = 0; i < 32; i++)
    begin
      lfsr = lfsr_next(lfsr);
      w[i] = lfsr[0];          // one step per bit
    end
  endtask

  task automatic report_fault(input string what);
    errors++;
    $display("error at %0t: %s", $time, what);
  endtask

  task automatic check_prod
  (
    input mul_pkg::product_t got,
    input mul_pkg::product_t exp,
    input string             msg
  );
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED @%0t: %s got %h exp %h", $time, msg, got, exp);
    end
  endtask

  task automatic check_resp
  (
    input mul_pkg::axi_resp_t got,
    input mul_pkg::axi_resp_t exp,
    input string              msg
  );
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED @%0t: %s got %b exp %b", $time, msg, got, exp);
    end
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string msg);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED @%0t: %s got %h exp %h", $time, msg, got, exp);
    end
  endtask

  // products pair up in push order
  always @(posedge clk)
  begin
    while (got_q.size() > 0 && exp_q.size() > 0)
      check_prod(got_q.pop_front(), exp_q.pop_front(), "PROD_HI:PROD_LO");
  end

  // ====================
  // bus tasks
  // ====================
  task automatic axi_write
  (
    input  logic [`MUL_AXI_ADDR_W-1:0] addr,
    input  logic [31:0]                data,
    input  int                         stall,   // cycles bready stays low
    output mul_pkg::axi_resp_t         resp
  );
    awaddr  <= addr;
    wdata   <= data;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    do
      @(posedge clk);
    while (!(awready && wready));   // taken on this edge
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    @(posedge clk);
    if (!bvalid)
      report_fault($sformatf("no write response in the cycle after the write to %h", addr));
    resp = bresp;
    for (int i = 0; i < stall; i++)
    begin
      @(posedge clk);
      if (!bvalid)
        report_fault("bvalid dropped while bready was low");
      check_resp(bresp, resp, "bresp under back-pressure");
    end
    bready <= 1'b1;
    @(posedge clk);                 // response handshake
    bready <= 1'b0;
  endtask

  task automatic axi_read
  (
    input  logic [`MUL_AXI_ADDR_W-1:0] addr,
    input  int                         stall,   // cycles rready stays low
    output logic [31:0]                data,
    output mul_pkg::axi_resp_t         resp
  );
    araddr  <= addr;
    arvalid <= 1'b1;
    do
      @(posedge clk);
    while (!arready);
    arvalid <= 1'b0;
    @(posedge clk);
    if (!rvalid)
      report_fault($sformatf("no read data in the cycle after the read of %h", addr));
    data = rdata;
    resp = rresp;
    for (int i = 0; i < stall; i++)
    begin
      @(posedge clk);
      if (!rvalid)
        report_fault("rvalid dropped while rready was low");
      check_word(rdata, data, "rdata under back-pressure");
      check_resp(rresp, resp, "rresp under back-pressure");
    end
    rready <= 1'b1;
    @(posedge clk);
    rready <= 1'b0;
  endtask

  task automatic write_reg(input logic [`MUL_AXI_ADDR_W-1:0] addr, input logic [31:0] data);
    mul_pkg::axi_resp_t r;
    axi_write(addr, data, 0, r);
    check_resp(r, mul_pkg::OKAY, $sformatf("bresp of write to %h", addr));
  endtask

  task automatic read_reg(input logic [`MUL_AXI_ADDR_W-1:0] addr, output logic [31:0] data);
    mul_pkg::axi_resp_t r;
    axi_read(addr, 0, data, r);
    check_resp(r, mul_pkg::OKAY, $sformatf("rresp of read from %h", addr));
  endtask

  // poll ctrl until idle and done has shown up at least once
  task automatic wait_idle();
    logic [31:0] w;
    logic        seen;
    seen = 1'b0;
    do
    begin
      read_reg(`MUL_REG_CTRL, w);
      seen = seen | w[1];
    end
    while (w[0] || !seen);
  endtask

  task automatic collect_prod(input mul_pkg::operand_t a, input mul_pkg::operand_t b);
    logic [31:0] lo;
    logic [31:0] hi;
    wait_idle();
    read_reg(`MUL_REG_PROD_LO, lo);
    read_reg(`MUL_REG_PROD_HI, hi);
    exp_q.push_back(ref_mul(a, b));
    got_q.push_back({hi, lo});
  endtask

  task automatic run_mul(input mul_pkg::operand_t a, input mul_pkg::operand_t b);
    write_reg(`MUL_REG_X, a);
    write_reg(`MUL_REG_Y, b);
    write_reg(`MUL_REG_CTRL, 32'd1);   // start
    exp_count = exp_count + 32'd1;
    collect_prod(a, b);
  endtask

  // ====================
  // test sequence
  // ====================
  initial
  begin
    mul_pkg::operand_t  a;
    mul_pkg::operand_t  b;
    mul_pkg::product_t  p;
    mul_pkg::axi_resp_t r;
    logic [31:0]        w;
    logic [31:0]        exp_regs [6];
    errors    = 0;
    checks    = 0;
    lfsr      = 16'd9746;
    exp_count = '0;
    rst_n     = 1'b0;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    for (int i = 0; i < 6; i++)        // x .. count all zero
    begin
      read_reg(5'(4 * i), w);
      check_word(w, 32'd0, $sformatf("reg %h after reset", 4 * i));
    end

    run_mul(32'd0, 32'h1234_5678);
    run_mul(32'hDEAD_BEEF, 32'd0);
    run_mul(32'd1, 32'hCAFE_F00D);
    run_mul(32'hFFFF_FFFF, 32'hFFFF_FFFF);
    run_mul(32'h8000_0000, 32'h8000_0001);   // top digit of x
    run_mul(32'hC000_0003, 32'hFFFF_FFFE);

    for (int i = 0; i < 200; i++)
    begin
      rand_operand(a);
      rand_operand(b);
      run_mul(a, b);
    end
    read_reg(`MUL_REG_COUNT, w);
    check_word(w, exp_count, "COUNT after random ops");

    // starts in a row with x moving each time
    b = 32'h0F0F_1234;
    write_reg(`MUL_REG_Y, b);
    for (int i = 0; i < 4; i++)
    begin
      rand_operand(a);
      write_reg(`MUL_REG_X, a);
      write_reg(`MUL_REG_CTRL, 32'd1);
    end
    exp_count = exp_count + 32'd4;
    collect_prod(a, b);                // last operands only
    read_reg(`MUL_REG_COUNT, w);
    check_word(w, exp_count, "COUNT after repeated starts");

    // slow bready and rready
    a = 32'h1357_9BDF;
    b = 32'h2468_ACE0;
    write_reg(`MUL_REG_X, a);
    axi_write(`MUL_REG_Y, b, 5, r);
    check_resp(r, mul_pkg::OKAY, "bresp of stalled write");
    axi_write(`MUL_REG_CTRL, 32'd1, 7, r);
    check_resp(r, mul_pkg::OKAY, "bresp of stalled start");
    exp_count = exp_count + 32'd1;
    collect_prod(a, b);
    p = ref_mul(a, b);
    axi_read(`MUL_REG_PROD_HI, 6, w, r);
    check_resp(r, mul_pkg::OKAY, "rresp of stalled read");
    check_word(w, p[63:32], "PROD_HI on stalled read");

    // unmapped offsets
    exp_regs[0] = a;
    exp_regs[1] = b;
    exp_regs[2] = 32'd0;               // idle with done cleared by the last poll
    exp_regs[3] = p[31:0];
    exp_regs[4] = p[63:32];
    exp_regs[5] = exp_count;
    for (int i = 0; i < 6; i++)
    begin
      read_reg(5'(4 * i), w);
      check_word(w, exp_regs[i], $sformatf("reg %h before unmapped access", 4 * i));
    end
    axi_write(5'h18, 32'hFFFF_FFFF, 0, r);
    check_resp(r, mul_pkg::SLVERR, "bresp at 0x18");
    axi_write(5'h1C, 32'h0000_0001, 2, r);
    check_resp(r, mul_pkg::SLVERR, "bresp at 0x1C");
    axi_write(5'h02, 32'hA5A5_A5A5, 0, r);   // inside x but unaligned
    check_resp(r, mul_pkg::SLVERR, "bresp at 0x02");
    axi_read(5'h18, 0, w, r);
    check_resp(r, mul_pkg::SLVERR, "rresp at 0x18");
    check_word(w, 32'd0, "rdata at 0x18");
    axi_read(5'h1F, 3, w, r);
    check_resp(r, mul_pkg::SLVERR, "rresp at 0x1F");
    check_word(w, 32'd0, "rdata at 0x1F");
    for (int i = 0; i < 6; i++)
    begin
      read_reg(5'(4 * i), w);
      check_word(w, exp_regs[i], $sformatf("reg %h after unmapped access", 4 * i));
    end

    repeat (2) @(posedge clk);         // let the compare process drain
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0 && exp_q.size() == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule : tb_mul_top

`default_nettype wire

// ==== verilog.f ====
+incdir+rtl
rtl/mul_pkg.sv
rtl/booth_pp_gen.sv
rtl/csa_tree.sv
rtl/mul_ctrl.sv
rtl/mul_top.sv
testbench/tb_mul_top.sv
